//--- list.f
logic/apb_iob_pkg.sv
logic/apb_to_iob.sv
logic/iob_reg_bank.sv
logic/apb_iob_top.sv
test/apb_iob_tb.sv

//--- logic/apb_iob_pkg.sv
// Fixed bus widths and register map shared by the bridge and the bank
// Eight 32-bit words, byte addressed, word-aligned accesses only

package apb_iob_pkg;

   localparam int ADDR_W  = 5;          // Byte address, 8 words
   localparam int DATA_W  = 32;
   localparam int WSTRB_W = DATA_W / 8;
   localparam int IDX_W   = ADDR_W - $clog2(WSTRB_W);  // Word index width

   // Register map, word indices
   localparam int NUM_SCRATCH = 6;      // Words 0 to 5
   localparam logic [IDX_W-1:0] REG_WAIT_CFG = 3'd6;
   localparam logic [IDX_W-1:0] REG_WR_COUNT = 3'd7;  // Read-only

   // Only the low bits of the wait configuration are used
   localparam int WAIT_W = 3;
   localparam logic [DATA_W-1:0] WAIT_RST = '0;

   // Bridge sequencer, same encoding as the APB2IOb block
   typedef enum logic [1:0] {
      WAIT_ENABLE    = 2'd0,
      WAIT_READY     = 2'd1,
      RVALID         = 2'd2,
      WAIT_APB_READY = 2'd3
   } bridge_state_t;

   // Register bank request handling
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      STALL = 2'd1,  // Counting wait cycles
      RESP  = 2'd2   // Read data on offer
   } bank_state_t;

endpackage

//--- logic/apb_iob_top.sv
// APB port onto the IOb register bank through the bridge
// Single subordinate, no address decode and no error response

`timescale 1ns/100ps

module apb_iob_top import apb_iob_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  logic               apb_sel_i,
   input  logic               apb_enable_i,
   input  logic               apb_write_i,
   input  logic [ADDR_W-1:0]  apb_addr_i,
   input  logic [DATA_W-1:0]  apb_wdata_i,
   input  logic [WSTRB_W-1:0] apb_wstrb_i,
   output logic               apb_ready_o,
   output logic [DATA_W-1:0]  apb_rdata_o
);

   // Internal IOb bus
   logic               iob_valid;
   logic [ADDR_W-1:0]  iob_addr;
   logic [DATA_W-1:0]  iob_wdata;
   logic [WSTRB_W-1:0] iob_wstrb;
   logic               iob_ready;
   logic               iob_rvalid;
   logic               iob_rready;
   logic [DATA_W-1:0]  iob_rdata;

   apb_to_iob bridge (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .apb_sel_i    (apb_sel_i),
      .apb_enable_i (apb_enable_i),
      .apb_write_i  (apb_write_i),
      .apb_addr_i   (apb_addr_i),
      .apb_wdata_i  (apb_wdata_i),
      .apb_wstrb_i  (apb_wstrb_i),
      .apb_ready_o  (apb_ready_o),
      .apb_rdata_o  (apb_rdata_o),
      .iob_ready_i  (iob_ready),
      .iob_rvalid_i (iob_rvalid),
      .iob_rdata_i  (iob_rdata),
      .iob_valid_o  (iob_valid),
      .iob_addr_o   (iob_addr),
      .iob_wdata_o  (iob_wdata),
      .iob_wstrb_o  (iob_wstrb),
      .iob_rready_o (iob_rready)
   );

   iob_reg_bank bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .iob_valid_i  (iob_valid),
      .iob_addr_i   (iob_addr),
      .iob_wdata_i  (iob_wdata),
      .iob_wstrb_i  (iob_wstrb),
      .iob_rready_i (iob_rready),
      .iob_ready_o  (iob_ready),
      .iob_rvalid_o (iob_rvalid),
      .iob_rdata_o  (iob_rdata)
   );

endmodule

//--- logic/apb_to_iob.sv
// APB subordinate to IOb manager, one transfer in flight at a time
// A write with all strobes low looks like a read on IOb, so writes need a strobe set
// PREADY is a one-cycle pulse from a register; no PSLVERR

`timescale 1ns/100ps

module apb_to_iob import apb_iob_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_n_i,

   // APB subordinate
   input  logic               apb_sel_i,
   input  logic               apb_enable_i,
   input  logic               apb_write_i,
   input  logic [ADDR_W-1:0]  apb_addr_i,
   input  logic [DATA_W-1:0]  apb_wdata_i,
   input  logic [WSTRB_W-1:0] apb_wstrb_i,
   output logic               apb_ready_o,
   output logic [DATA_W-1:0]  apb_rdata_o,

   // IOb manager
   input  logic               iob_ready_i,
   input  logic               iob_rvalid_i,
   input  logic [DATA_W-1:0]  iob_rdata_i,
   output logic               iob_valid_o,
   output logic [ADDR_W-1:0]  iob_addr_o,
   output logic [DATA_W-1:0]  iob_wdata_o,
   output logic [WSTRB_W-1:0] iob_wstrb_o,
   output logic               iob_rready_o
);

   bridge_state_t state_q;
   bridge_state_t state_d;
   logic          iob_valid;
   logic          iob_rready;
   logic          apb_ready_d;

   // Request fields come straight from the APB bus, held by the manager
   assign iob_addr_o   = apb_addr_i;
   assign iob_wdata_o  = apb_wdata_i;
   assign iob_wstrb_o  = apb_write_i ? apb_wstrb_i : '0;  // Zero strobes mean read
   assign iob_valid_o  = iob_valid;
   assign iob_rready_o = iob_rready;

   always_comb begin
      state_d     = state_q;
      iob_valid   = 1'b0;
      iob_rready  = 1'b0;
      apb_ready_d = 1'b0;

      case (state_q)
         WAIT_ENABLE: begin
            // Request goes out in the first access cycle
            iob_valid = apb_sel_i & apb_enable_i;
            if (iob_valid) begin
               state_d = WAIT_READY;
            end
         end
         WAIT_READY: begin
            iob_valid = 1'b1;  // Held until the bank takes it
         end
         RVALID: begin
            iob_rready  = 1'b1;
            apb_ready_d = iob_rvalid_i;
            if (iob_rvalid_i) begin
               state_d = WAIT_APB_READY;
            end
         end
         default: begin
            // PREADY is high this cycle, manager drops PENABLE after it
            state_d = WAIT_ENABLE;
         end
      endcase

      // Acceptance, also possible in the first access cycle
      if (iob_valid && iob_ready_i) begin
         if (apb_write_i) begin
            state_d     = WAIT_APB_READY;
            apb_ready_d = 1'b1;
         end else begin
            state_d = RVALID;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WAIT_ENABLE;
      end else begin
         state_q <= state_d;
      end
   end

   // PREADY one cycle after the IOb side completes
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         apb_ready_o <= 1'b0;
      end else begin
         apb_ready_o <= apb_ready_d;
      end
   end

   // Read data capture
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         apb_rdata_o <= '0;
      end else if (iob_rvalid_i) begin
         apb_rdata_o <= iob_rdata_i;
      end
   end

endmodule

//--- logic/iob_reg_bank.sv
// IOb register bank: 6 scratch words, wait configuration, write counter
// Wait cycles come from the low WAIT_W bits of word 6; word 7 ignores writes
// Address bits below the word index are not decoded

`timescale 1ns/100ps

module iob_reg_bank import apb_iob_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  logic               iob_valid_i,
   input  logic [ADDR_W-1:0]  iob_addr_i,
   input  logic [DATA_W-1:0]  iob_wdata_i,
   input  logic [WSTRB_W-1:0] iob_wstrb_i,
   input  logic               iob_rready_i,
   output logic               iob_ready_o,
   output logic               iob_rvalid_o,
   output logic [DATA_W-1:0]  iob_rdata_o
);

   bank_state_t       state_q;
   bank_state_t       state_d;
   logic [WAIT_W-1:0] wait_cnt_q;
   logic [WAIT_W-1:0] wait_cycles;

   logic [DATA_W-1:0] scratch_q [NUM_SCRATCH];
   logic [DATA_W-1:0] wait_cfg_q;
   logic [DATA_W-1:0] wr_count_q;
   logic [DATA_W-1:0] rd_word;

   logic [IDX_W-1:0]  word_idx;
   logic              is_read;
   logic              wr_accept;
   logic              rd_accept;

   // Byte lane merge for strobed writes
   function automatic logic [DATA_W-1:0] byte_merge(
      input logic [DATA_W-1:0]  old_word,
      input logic [DATA_W-1:0]  new_word,
      input logic [WSTRB_W-1:0] strb
   );
      logic [DATA_W-1:0] merged;
      merged = old_word;
      for (int b = 0; b < WSTRB_W; b++) begin
         if (strb[b]) begin
            merged[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return merged;
   endfunction

   assign word_idx    = iob_addr_i[ADDR_W-1 -: IDX_W];
   assign wait_cycles = wait_cfg_q[WAIT_W-1:0];
   assign is_read     = ~(|iob_wstrb_i);
   assign wr_accept   = iob_valid_i & iob_ready_o & ~is_read;
   assign rd_accept   = iob_valid_i & iob_ready_o & is_read;

   assign iob_rvalid_o = (state_q == RESP);  // Held until the manager takes it

   // Request controller; ready is a one-cycle pulse once the wait is over
   always_comb begin
      state_d     = state_q;
      iob_ready_o = 1'b0;

      case (state_q)
         IDLE: begin
            if (iob_valid_i) begin
               if (wait_cycles == '0) begin
                  iob_ready_o = 1'b1;
                  state_d     = is_read ? RESP : IDLE;
               end else begin
                  state_d = STALL;
               end
            end
         end
         STALL: begin
            if (wait_cnt_q == '0) begin
               iob_ready_o = 1'b1;
               state_d     = is_read ? RESP : IDLE;
            end
         end
         RESP: begin
            if (iob_rready_i) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         wait_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == IDLE && iob_valid_i && wait_cycles != '0) begin
            wait_cnt_q <= wait_cycles - 1'b1;  // Cycle 0 already spent in IDLE
         end else if (state_q == STALL && wait_cnt_q != '0) begin
            wait_cnt_q <= wait_cnt_q - 1'b1;
         end
      end
   end

   // Register writes; every accepted write is counted, word 7 included
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_SCRATCH; i++) begin
            scratch_q[i] <= '0;
         end
         wait_cfg_q <= WAIT_RST;
         wr_count_q <= '0;
      end else if (wr_accept) begin
         wr_count_q <= wr_count_q + 1'b1;  // Wraps
         if (word_idx == REG_WAIT_CFG) begin
            wait_cfg_q <= byte_merge(wait_cfg_q, iob_wdata_i, iob_wstrb_i);
         end else if (int'(word_idx) < NUM_SCRATCH) begin
            scratch_q[word_idx] <= byte_merge(scratch_q[word_idx], iob_wdata_i, iob_wstrb_i);
         end
      end
   end

   // Read word select
   always_comb begin
      case (word_idx)
         REG_WAIT_CFG: rd_word = wait_cfg_q;
         REG_WR_COUNT: rd_word = wr_count_q;
         default:      rd_word = scratch_q[word_idx];
      endcase
   end

   // Read response data, stable while rvalid is held
   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         iob_rdata_o <= rd_word;
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the APB to IOb testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module apb_iob_tb \
   -f list.f \
   -o apb_iob_sim

./obj_dir/apb_iob_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "test failed" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

//--- test/apb_iob_tb.sv
// APB manager testbench for apb_iob_top, run from the project root
// Vectors come from test/apb_iob_vectors.txt, then seeded random write/read pairs
// Latency is checked against the wait value the model expects before each transfer

`timescale 1ns/100ps

module apb_iob_tb import apb_iob_pkg::*; ();

   localparam int CLK_HALF     = 50;
   localparam int CLK_PERIOD   = 2 * CLK_HALF;
   localparam int MAX_WAIT_CYC = 20;   // PREADY limit per transfer
   localparam int RAND_PAIRS   = 40;
   localparam int CYC_PER_XFER = 12;

   logic               clk = 1'b0;
   logic               rst_n;
   logic               apb_sel;
   logic               apb_enable;
   logic               apb_write;
   logic [ADDR_W-1:0]  apb_addr;
   logic [DATA_W-1:0]  apb_wdata;
   logic [WSTRB_W-1:0] apb_wstrb;
   logic               apb_ready;
   logic [DATA_W-1:0]  apb_rdata;

   // Reference model of the register map
   logic [DATA_W-1:0]  model_mem [8];
   logic [DATA_W-1:0]  model_count;

   // Vector storage
   logic [7:0]         vec_kind [$];
   logic [ADDR_W-1:0]  vec_addr [$];
   logic [WSTRB_W-1:0] vec_strb [$];
   logic [DATA_W-1:0]  vec_wdata [$];
   logic [DATA_W-1:0]  vec_expected [$];

   int     data_errors  = 0;
   int     lat_errors   = 0;
   int     other_errors = 0;
   int     vec_count    = 0;
   bit     vectors_loaded = 1'b0;
   integer seed;

   apb_iob_top UUT (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .apb_sel_i    (apb_sel),
      .apb_enable_i (apb_enable),
      .apb_write_i  (apb_write),
      .apb_addr_i   (apb_addr),
      .apb_wdata_i  (apb_wdata),
      .apb_wstrb_i  (apb_wstrb),
      .apb_ready_o  (apb_ready),
      .apb_rdata_o  (apb_rdata)
   );

   always #(CLK_HALF) clk = ~clk;

   // Byte lanes from new_w where the strobe is set, old_w elsewhere
   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0]  old_w,
      input logic [DATA_W-1:0]  new_w,
      input logic [WSTRB_W-1:0] strb
   );
      logic [DATA_W-1:0] mask;
      for (int b = 0; b < WSTRB_W; b++) begin
         mask[8*b +: 8] = {8{strb[b]}};
      end
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   task automatic record_write(
      input logic [ADDR_W-1:0]  addr,
      input logic [WSTRB_W-1:0] strb,
      input logic [DATA_W-1:0]  wdata
   );
      logic [2:0] idx;
      idx = addr[ADDR_W-1:2];
      model_count = model_count + 32'd1;   // Counter word takes no data
      if (idx != 3'd7) begin
         model_mem[idx] = merge_bytes(model_mem[idx], wdata, strb);
      end
   endtask

   task automatic load_vectors();
      integer             fd;
      integer             n;
      string              line;
      logic [7:0]         kind;
      logic [ADDR_W-1:0]  addr;
      logic [WSTRB_W-1:0] strb;
      logic [DATA_W-1:0]  wdata;
      logic [DATA_W-1:0]  expected;
      fd = $fopen("test/apb_iob_vectors.txt", "r");
      assert (fd != 0) else begin
         $display("Could not open the vector file test/apb_iob_vectors.txt");
         other_errors++;
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h %h %h", kind, addr, strb, wdata, expected);
               assert (n == 5 && (kind == "W" || kind == "R")) else begin
                  $display("Skipped a vector line that does not parse: %s", line);
                  other_errors++;
               end
               if (n == 5 && (kind == "W" || kind == "R")) begin
                  vec_kind.push_back(kind);
                  vec_addr.push_back(addr);
                  vec_strb.push_back(strb);
                  vec_wdata.push_back(wdata);
                  vec_expected.push_back(expected);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // One APB transfer: setup, access, wait for PREADY, check
   task automatic apb_transfer(
      input logic               is_write,
      input logic [ADDR_W-1:0]  addr,
      input logic [WSTRB_W-1:0] strb,
      input logic [DATA_W-1:0]  wdata,
      input logic [DATA_W-1:0]  expected
   );
      int                cycles;
      int                exp_cycles;
      logic [WAIT_W-1:0] wait_now;
      wait_now   = model_mem[6][WAIT_W-1:0];   // Wait in force for this request
      exp_cycles = is_write ? int'(wait_now) + 1 : int'(wait_now) + 2;

      @(posedge clk);
      apb_sel    <= 1'b1;
      apb_enable <= 1'b0;
      apb_write  <= is_write;
      apb_addr   <= addr;
      apb_wdata  <= wdata;
      apb_wstrb  <= is_write ? strb : '0;
      @(posedge clk);
      apb_enable <= 1'b1;   // Cycle 0 of the access phase
      cycles = 0;
      @(negedge clk);
      while (!apb_ready && cycles < MAX_WAIT_CYC) begin
         @(negedge clk);
         cycles++;
      end

      assert (apb_ready) else begin
         $display("No PREADY within %0d cycles for the access to address %h",
                  MAX_WAIT_CYC, addr);
         other_errors++;
      end
      if (apb_ready) begin
         assert (cycles == exp_cycles) else begin
            $display("Fail apb_ready_o latency expected %h actual %h at address %h",
                     exp_cycles, cycles, addr);
            lat_errors++;
         end
         if (!is_write) begin
            assert (apb_rdata == expected) else begin
               $display("Fail apb_rdata_o expected %h actual %h at address %h",
                        expected, apb_rdata, addr);
               data_errors++;
            end
         end
      end
      if (is_write) begin
         record_write(addr, strb, wdata);
      end

      @(posedge clk);
      apb_sel    <= 1'b0;
      apb_enable <= 1'b0;
      apb_write  <= 1'b0;
      @(negedge clk);
      assert (!apb_ready) else begin
         $display("Fail apb_ready_o expected %h actual %h after the pulse", 1'b0, apb_ready);
         lat_errors++;
      end
   endtask

   task automatic run_random_pairs();
      int unsigned        idx;
      logic [ADDR_W-1:0]  addr;
      logic [WSTRB_W-1:0] strb;
      logic [DATA_W-1:0]  data;
      for (int p = 0; p < RAND_PAIRS; p++) begin
         idx  = $unsigned($random(seed)) % NUM_SCRATCH;
         data = $random(seed);
         strb = WSTRB_W'($random(seed));
         if (strb == '0) begin
            strb = '1;   // No strobes would turn it into a read
         end
         addr = ADDR_W'(idx * 4);
         apb_transfer(1'b1, addr, strb, data, '0);
         apb_transfer(1'b0, addr, '0, '0, model_mem[idx]);
      end
      apb_transfer(1'b0, {REG_WR_COUNT, 2'b00}, '0, '0, model_count);
   endtask

   initial begin
      apb_sel    <= 1'b0;
      apb_enable <= 1'b0;
      apb_write  <= 1'b0;
      apb_addr   <= '0;
      apb_wdata  <= '0;
      apb_wstrb  <= '0;
      rst_n      <= 1'b0;
      seed        = 25550;
      model_count = '0;
      for (int i = 0; i < 8; i++) begin
         model_mem[i] = '0;
      end

      load_vectors();
      vec_count      = vec_kind.size();
      vectors_loaded = 1'b1;

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < vec_count; i++) begin
         apb_transfer(vec_kind[i] == "W", vec_addr[i], vec_strb[i],
                      vec_wdata[i], vec_expected[i]);
      end
      run_random_pairs();

      $display("Errors: %0d data, %0d latency, %0d other",
               data_errors, lat_errors, other_errors);
      if (data_errors + lat_errors + other_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Watchdog, sized from the number of transfers
   initial begin
      longint        limit_ns;
      bridge_state_t bstate;
      wait (vectors_loaded);
      limit_ns = longint'(vec_count + 2 * RAND_PAIRS) * CYC_PER_XFER * CLK_PERIOD;
      #(limit_ns);
      bstate = UUT.bridge.state_q;
      $display("Timeout: the run did not finish within %0d ns, bridge state %s",
               limit_ns, bstate.name());
      $display("Errors: %0d data, %0d latency, %0d other",
               data_errors, lat_errors, other_errors);
      $display("test failed");
      $finish;
   end

endmodule

//--- test/apb_iob_vectors.txt
# kind(W/R) addr(hex byte) strobes(hex) wdata(hex) expected_rdata(hex)
# expected column is ignored on writes; strobes and wdata are ignored on reads
R 00 0 00000000 00000000
R 04 0 00000000 00000000
R 08 0 00000000 00000000
R 0C 0 00000000 00000000
R 10 0 00000000 00000000
R 14 0 00000000 00000000
R 18 0 00000000 00000000
R 1C 0 00000000 00000000
W 00 f 11111111 00000000
W 04 f a5a5a5a5 00000000
W 08 f 12345678 00000000
W 0C f deadbeef 00000000
W 10 f 0badf00d 00000000
W 14 f cafef00d 00000000
R 00 0 00000000 11111111
R 04 0 00000000 a5a5a5a5
R 08 0 00000000 12345678
R 0C 0 00000000 deadbeef
R 10 0 00000000 0badf00d
R 14 0 00000000 cafef00d
W 00 1 aabbccdd 00000000
W 04 6 00ff00ff 00000000
W 08 8 ffeeddcc 00000000
W 0C 5 01020304 00000000
W 10 a 55667788 00000000
W 14 3 9abcdef0 00000000
R 00 0 00000000 111111dd
R 04 0 00000000 a5ff00a5
R 08 0 00000000 ff345678
R 0C 0 00000000 de02be04
R 10 0 00000000 55ad770d
R 14 0 00000000 cafedef0
W 18 1 00000003 00000000
R 18 0 00000000 00000003
R 00 0 00000000 111111dd
W 08 f 76543210 00000000
R 08 0 00000000 76543210
W 18 f 00000007 00000000
R 18 0 00000000 00000007
R 0C 0 00000000 de02be04
W 0C 2 0000aa00 00000000
R 0C 0 00000000 de02aa04
W 18 f fffffff8 00000000
R 18 0 00000000 fffffff8
R 1C 0 00000000 00000011
W 1C f 12345678 00000000
R 1C 0 00000000 00000012
W 18 1 00000003 00000000
R 1C 0 00000000 00000013
W 18 f 00000000 00000000
R 18 0 00000000 00000000
R 1C 0 00000000 00000014
